/* verilog/lpf_consts.svh */
// ------------------------------------------------
// Fixed-point formats and sequencer program codes
// Coefficients are Q1.17, so one half is 2**16
// ------------------------------------------------
`ifndef LPF_CONSTS_SVH
`define LPF_CONSTS_SVH

`define LPF_SAMPLE_W   18
`define LPF_COEF_W     18
`define LPF_COEF_HALF  18'sd65536
`define LPF_COEF_SHIFT 17
`define LPF_FIFO_DEPTH 2
`define LPF_DSM_FS     131072

// Sequencer program
`define LPF_PROG_LEN       10
`define LPF_TASK_WAIT_IN   3'd0
`define LPF_TASK_START_1   3'd1
`define LPF_TASK_WAIT_DONE 3'd2
`define LPF_TASK_POP_2     3'd3
`define LPF_TASK_JUMP_0    3'd4

`endif

/* verilog/lpf_pkg.sv */
// ------------------------------------------------
// Sample, stereo pair and MAC request types
// Accumulator is 48 bits, wide enough for any sum
// ------------------------------------------------
`include "lpf_consts.svh"

package lpf_pkg;

    typedef logic signed [`LPF_SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        sample_t l;
        sample_t r;
    } stereo_t;

    // One request per lane and cycle
    typedef struct packed {
        logic                          clear;
        logic                          valid;
        sample_t                       operand;
        logic signed [`LPF_COEF_W-1:0] coef;
    } mac_req_t;

    typedef logic signed [47:0] acc_t;

endpackage

/* verilog/sample_fifo.sv */
// ------------------------------------------------
// Synchronous FIFO, head shown combinationally
// Push when full and pop when empty are dropped
// ------------------------------------------------
`include "lpf_consts.svh"

module sample_fifo #(
    parameter type payload_t = logic [35:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     empty,
    output logic     full
);

    localparam int depth = `LPF_FIFO_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t           mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth));
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* verilog/interp_2x.sv */
// ------------------------------------------------
// Linear 2x interpolator, 6 cycles start to done
// Needs the MAC result two edges after a request
// Start is ignored while busy
// ------------------------------------------------
`include "lpf_consts.svh"

module interp_2x (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  lpf_pkg::stereo_t   sample_in,
    output lpf_pkg::mac_req_t  mac_req_l,
    output lpf_pkg::mac_req_t  mac_req_r,
    input  lpf_pkg::acc_t      acc_l,
    input  lpf_pkg::acc_t      acc_r,
    output logic               out_rdy,
    output lpf_pkg::stereo_t   sample_out,
    output logic               busy,
    output logic               done
);

    // Cycle numbers counted from the start pulse
    localparam logic [2:0] cyc_req_prev = 3'd1;
    localparam logic [2:0] cyc_req_cur  = 3'd2;
    localparam logic [2:0] cyc_mid      = 3'd4;
    localparam logic [2:0] cyc_cur      = 3'd5;
    localparam logic [2:0] cyc_done     = 3'd6;

    logic [2:0]       cnt;
    lpf_pkg::stereo_t prev_q;
    lpf_pkg::stereo_t cur_q;
    lpf_pkg::stereo_t mid;
    lpf_pkg::acc_t    mid_acc_l;
    lpf_pkg::acc_t    mid_acc_r;

    function automatic lpf_pkg::mac_req_t half_req(input logic clr, input lpf_pkg::sample_t x);
        lpf_pkg::mac_req_t req;
        req.clear   = clr;
        req.valid   = 1'b1;
        req.operand = x;
        req.coef    = `LPF_COEF_HALF;
        return req;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (start && !busy) begin
            cnt <= 3'd1;
        end else if (cnt == cyc_done) begin
            cnt <= '0;
        end else if (busy) begin
            cnt <= cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            cur_q <= sample_in;
        end
    end

    // History advances once the pair is out
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_q <= '0;
        end else if (cnt == cyc_done) begin
            prev_q <= cur_q;
        end
    end

    always_comb begin
        mac_req_l = '0;
        mac_req_r = '0;
        if (cnt == cyc_req_prev) begin
            mac_req_l = half_req(1'b1, prev_q.l);
            mac_req_r = half_req(1'b1, prev_q.r);
        end else if (cnt == cyc_req_cur) begin
            mac_req_l = half_req(1'b0, cur_q.l);
            mac_req_r = half_req(1'b0, cur_q.r);
        end
    end

    // prev/2 + cur/2 scaled back, floor by arithmetic shift
    assign mid_acc_l = acc_l >>> `LPF_COEF_SHIFT;
    assign mid_acc_r = acc_r >>> `LPF_COEF_SHIFT;
    assign mid.l     = mid_acc_l[`LPF_SAMPLE_W-1:0];
    assign mid.r     = mid_acc_r[`LPF_SAMPLE_W-1:0];

    assign busy       = (cnt != '0);
    assign out_rdy    = (cnt == cyc_mid) || (cnt == cyc_cur);
    assign sample_out = (cnt == cyc_mid) ? mid : cur_q;
    assign done       = (cnt == cyc_done);

endmodule

/* verilog/mac_unit.sv */
// ------------------------------------------------
// Two-lane signed MAC, request at edge N gives
// its accumulator for sampling at edge N+2
// ------------------------------------------------

module mac_unit (
    input  logic              clk,
    input  logic              reset,
    input  lpf_pkg::mac_req_t req_l,
    input  lpf_pkg::mac_req_t req_r,
    output lpf_pkg::acc_t     acc_l,
    output lpf_pkg::acc_t     acc_r
);

    lpf_pkg::mac_req_t req [2];
    lpf_pkg::acc_t     acc [2];

    assign req[0] = req_l;
    assign req[1] = req_r;
    assign acc_l  = acc[0];
    assign acc_r  = acc[1];

    for (genvar i = 0; i < 2; i++) begin : g_lane
        logic          v_q;
        logic          clr_q;
        lpf_pkg::acc_t prod_q;
        lpf_pkg::acc_t acc_q;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                v_q   <= 1'b0;
                clr_q <= 1'b0;
            end else begin
                v_q   <= req[i].valid;
                clr_q <= req[i].clear;
            end
        end

        // Product stage, then accumulate
        always_ff @(posedge clk) begin
            prod_q <= req[i].operand * req[i].coef;
            if (v_q) begin
                acc_q <= clr_q ? prod_q : acc_q + prod_q;
            end
        end

        assign acc[i] = acc_q;
    end

endmodule

/* verilog/sigma_delta_mod.sv */
// ------------------------------------------------
// First-order 1-bit modulator, one channel
// Idle with output low until the first load
// ------------------------------------------------
`include "lpf_consts.svh"

module sigma_delta_mod (
    input  logic             clk,
    input  logic             reset,
    input  logic             load,
    input  lpf_pkg::sample_t sample,
    output logic             bit_out
);

    localparam logic signed [19:0] fs = `LPF_DSM_FS;

    lpf_pkg::sample_t   sample_q;
    logic               running;
    logic signed [19:0] err_q;
    logic signed [19:0] sample_ext;
    logic               bit_next;

    assign sample_ext = sample_q;
    assign bit_next   = (err_q >= 0);

    always_ff @(posedge clk) begin
        if (load) begin
            sample_q <= sample;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            err_q   <= '0;
            bit_out <= 1'b0;
        end else begin
            if (load) begin
                running <= 1'b1;
            end
            if (running) begin
                bit_out <= bit_next;
                // Feed back +/- full scale
                err_q   <= bit_next ? err_q + sample_ext - fs : err_q + sample_ext + fs;
            end
        end
    end

endmodule

/* verilog/lpf_chain.sv */
// ------------------------------------------------
// Stereo 4x upsampler with 1-bit DAC modulators
// Input strobes outside WAIT_IN are dropped
// ------------------------------------------------
`include "lpf_consts.svh"

module lpf_chain (
    input  logic             clk,
    input  logic             reset,
    input  logic             sample_in_rdy,
    input  lpf_pkg::sample_t sample_in_l,
    input  lpf_pkg::sample_t sample_in_r,
    output logic             sample_out_rdy,
    output lpf_pkg::sample_t sample_out_l,
    output lpf_pkg::sample_t sample_out_r,
    output logic             dac_out_l,
    output logic             dac_out_r
);

    localparam int pc_w = $clog2(`LPF_PROG_LEN);

    logic [pc_w-1:0]   pc;
    logic [2:0]        step_task;
    logic              owner_s2;
    lpf_pkg::stereo_t  in_q;
    logic              fifo_push, fifo_pop, fifo_empty, fifo_full;
    lpf_pkg::stereo_t  fifo_out;
    logic              s1_start, s1_busy, s1_done, s1_out_rdy;
    logic              s2_start, s2_busy, s2_done, s2_out_rdy;
    lpf_pkg::stereo_t  s1_out, s2_out;
    lpf_pkg::mac_req_t s1_req_l, s1_req_r, s2_req_l, s2_req_r;
    lpf_pkg::mac_req_t mac_req_l, mac_req_r;
    lpf_pkg::acc_t     acc_l, acc_r;

    // ------------------------------------------------
    // Sequencer
    // ------------------------------------------------
    always_comb begin
        case (pc)
            0:       step_task = `LPF_TASK_WAIT_IN;
            1:       step_task = `LPF_TASK_START_1;
            2:       step_task = `LPF_TASK_WAIT_DONE;
            3:       step_task = `LPF_TASK_POP_2;
            4:       step_task = `LPF_TASK_WAIT_DONE;
            5:       step_task = `LPF_TASK_POP_2;
            6:       step_task = `LPF_TASK_WAIT_DONE;
            default: step_task = `LPF_TASK_JUMP_0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= '0;
            owner_s2 <= 1'b0;
        end else begin
            case (step_task)
                `LPF_TASK_WAIT_IN:   if (sample_in_rdy) pc <= pc + 1'b1;
                `LPF_TASK_WAIT_DONE: if (s1_done || s2_done) pc <= pc + 1'b1;
                `LPF_TASK_JUMP_0:    pc <= '0;
                default:             pc <= pc + 1'b1;
            endcase
            // MAC goes to whichever stage starts
            if (s1_start) owner_s2 <= 1'b0;
            if (s2_start) owner_s2 <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (step_task == `LPF_TASK_WAIT_IN && sample_in_rdy) begin
            in_q <= '{l: sample_in_l, r: sample_in_r};
        end
    end

    assign s1_start  = (step_task == `LPF_TASK_START_1);
    assign fifo_pop  = (step_task == `LPF_TASK_POP_2);
    assign s2_start  = fifo_pop && !fifo_empty;
    assign fifo_push = s1_out_rdy;

    assign mac_req_l = owner_s2 ? s2_req_l : s1_req_l;
    assign mac_req_r = owner_s2 ? s2_req_r : s1_req_r;

    // ------------------------------------------------
    // Datapath
    // ------------------------------------------------
    interp_2x stage1_i (
        .clk(clk), .reset(reset), .start(s1_start), .sample_in(in_q),
        .mac_req_l(s1_req_l), .mac_req_r(s1_req_r), .acc_l(acc_l), .acc_r(acc_r),
        .out_rdy(s1_out_rdy), .sample_out(s1_out), .busy(s1_busy), .done(s1_done)
    );

    sample_fifo #(.payload_t(lpf_pkg::stereo_t)) fifo_i (
        .clk(clk), .reset(reset), .push(fifo_push), .pop(fifo_pop),
        .data_in(s1_out), .data_out(fifo_out), .empty(fifo_empty), .full(fifo_full)
    );

    interp_2x stage2_i (
        .clk(clk), .reset(reset), .start(s2_start), .sample_in(fifo_out),
        .mac_req_l(s2_req_l), .mac_req_r(s2_req_r), .acc_l(acc_l), .acc_r(acc_r),
        .out_rdy(s2_out_rdy), .sample_out(s2_out), .busy(s2_busy), .done(s2_done)
    );

    mac_unit mac_i (
        .clk(clk), .reset(reset), .req_l(mac_req_l), .req_r(mac_req_r),
        .acc_l(acc_l), .acc_r(acc_r)
    );

    sigma_delta_mod dsm_l_i (
        .clk(clk), .reset(reset), .load(s2_out_rdy), .sample(s2_out.l), .bit_out(dac_out_l)
    );

    sigma_delta_mod dsm_r_i (
        .clk(clk), .reset(reset), .load(s2_out_rdy), .sample(s2_out.r), .bit_out(dac_out_r)
    );

    assign sample_out_rdy = s2_out_rdy;
    assign sample_out_l   = s2_out.l;
    assign sample_out_r   = s2_out.r;

endmodule

/* test/lpf_chain_assert.sv */
// ------------------------------------------------
// Sequencer and FIFO rules checked inside lpf_chain
// Failures are counted in assert_fails
// ------------------------------------------------

module lpf_chain_assert (
    input logic clk,
    input logic reset,
    input logic sample_out_rdy,
    input logic fifo_push,
    input logic fifo_pop,
    input logic fifo_full,
    input logic fifo_empty,
    input logic s1_busy,
    input logic s2_busy
);

    int assert_fails = 0;

    // Stage 2 emits midpoint and current sample back to back, never a third
    out_rdy_pairs: assert property (@(posedge clk) disable iff (reset)
        sample_out_rdy ##1 sample_out_rdy |=> !sample_out_rdy)
        else begin
            $error("sample_out_rdy high on three cycles in a row");
            assert_fails++;
        end

    // FIFO depth covers the two stage 1 outputs
    fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        fifo_push |-> !fifo_full)
        else begin
            $error("FIFO pushed while full");
            assert_fails++;
        end

    fifo_no_underflow: assert property (@(posedge clk) disable iff (reset)
        fifo_pop |-> !fifo_empty)
        else begin
            $error("FIFO popped while empty");
            assert_fails++;
        end

    stages_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(s1_busy && s2_busy))
        else begin
            $error("both stages busy, MAC shared by two owners");
            assert_fails++;
        end

endmodule

bind lpf_chain lpf_chain_assert assert_i (
    .clk(clk), .reset(reset), .sample_out_rdy(sample_out_rdy),
    .fifo_push(fifo_push), .fifo_pop(fifo_pop), .fifo_full(fifo_full),
    .fifo_empty(fifo_empty), .s1_busy(s1_busy), .s2_busy(s2_busy)
);

/* test/lpf_chain_tb.sv */
// ------------------------------------------------
// Directed tests for lpf_chain, one input in flight
// Outputs sampled on the falling clock edge
// ------------------------------------------------
`include "lpf_consts.svh"

module lpf_chain_tb;

    localparam int max_wait = 200;
    localparam lpf_pkg::sample_t fs_pos = 18'sh1ffff;
    localparam lpf_pkg::sample_t fs_neg = 18'sh20000;
    localparam lpf_pkg::sample_t half_pos = `LPF_DSM_FS / 2;

    logic             clk;
    logic             reset;
    logic             sample_in_rdy;
    lpf_pkg::sample_t sample_in_l;
    lpf_pkg::sample_t sample_in_r;
    logic             sample_out_rdy;
    lpf_pkg::sample_t sample_out_l;
    lpf_pkg::sample_t sample_out_r;
    logic             dac_out_l;
    logic             dac_out_r;

    logic [31:0]      lcg_state;
    int               p1_l;
    int               p1_r;
    int               p2_l;
    int               p2_r;
    lpf_pkg::stereo_t expected [4];
    int               test_errors;
    int               tests_passed;
    int               tests_failed;
    int               conv_cycles;

    lpf_chain dut_i (
        .clk(clk), .reset(reset), .sample_in_rdy(sample_in_rdy),
        .sample_in_l(sample_in_l), .sample_in_r(sample_in_r),
        .sample_out_rdy(sample_out_rdy), .sample_out_l(sample_out_l),
        .sample_out_r(sample_out_r), .dac_out_l(dac_out_l), .dac_out_r(dac_out_r)
    );

    always #5 clk = ~clk;

    function automatic lpf_pkg::sample_t lcg_sample();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:14];
    endfunction

    // Floor of the mean, shift rounds toward minus infinity
    function automatic int floor_half(input int a, input int b);
        int s;
        s = a + b;
        return s >>> 1;
    endfunction

    // ------------------------------------------------
    // Reference model of the two linear stages
    // ------------------------------------------------
    task automatic predict(input int xl, input int xr);
        int ml;
        int mr;
        ml = floor_half(p1_l, xl);
        mr = floor_half(p1_r, xr);
        expected[0].l = lpf_pkg::sample_t'(floor_half(p2_l, ml));
        expected[0].r = lpf_pkg::sample_t'(floor_half(p2_r, mr));
        expected[1].l = lpf_pkg::sample_t'(ml);
        expected[1].r = lpf_pkg::sample_t'(mr);
        expected[2].l = lpf_pkg::sample_t'(floor_half(ml, xl));
        expected[2].r = lpf_pkg::sample_t'(floor_half(mr, xr));
        expected[3].l = lpf_pkg::sample_t'(xl);
        expected[3].r = lpf_pkg::sample_t'(xr);
        p1_l = xl;
        p2_l = xl;
        p1_r = xr;
        p2_r = xr;
    endtask

    task automatic check_stereo(input string name, input lpf_pkg::stereo_t exp_v,
                                input lpf_pkg::stereo_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected l=%0d r=%0d, actual l=%0d r=%0d", name,
                     $signed(exp_v.l), $signed(exp_v.r), $signed(act_v.l), $signed(act_v.r));
            test_errors++;
        end
    endtask

    task automatic check_density(input string name, input int lo, input int hi, input int act);
        if (act < lo || act > hi) begin
            $display("MISMATCH %s: expected %0d to %0d ones, actual %0d", name, lo, hi, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp_v, input int act);
        if (act != exp_v) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp_v, act);
            test_errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_input(input lpf_pkg::sample_t xl, input lpf_pkg::sample_t xr);
        @(posedge clk);
        sample_in_rdy <= 1'b1;
        sample_in_l   <= xl;
        sample_in_r   <= xr;
        @(posedge clk);
        sample_in_rdy <= 1'b0;
    endtask

    task automatic collect_outputs(input string name);
        int got;
        int waited;
        lpf_pkg::stereo_t act;
        got = 0;
        waited = 0;
        while (got < 4 && waited < max_wait) begin
            @(negedge clk);
            waited++;
            if (sample_out_rdy) begin
                act.l = sample_out_l;
                act.r = sample_out_r;
                check_stereo(name, expected[got], act);
                got++;
            end
        end
        conv_cycles = waited;
        if (got < 4) begin
            $display("%s: outputs never arrived within %0d cycles", name, max_wait);
            test_errors++;
        end
        // Sequencer needs a few cycles to get back to WAIT_IN
        wait_cycles(5);
    endtask

    task automatic convert(input string name, input lpf_pkg::sample_t xl,
                           input lpf_pkg::sample_t xr);
        predict(xl, xr);
        send_input(xl, xr);
        collect_outputs(name);
    endtask

    task automatic count_ones(input int n, output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (n) begin
            @(negedge clk);
            ones_l += dac_out_l;
            ones_r += dac_out_r;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // ------------------------------------------------
    // Tests
    // ------------------------------------------------
    task automatic test_idle();
        int pulses;
        int ones_l;
        int ones_r;
        pulses = 0;
        repeat (50) begin
            @(negedge clk);
            pulses += sample_out_rdy;
        end
        count_ones(50, ones_l, ones_r);
        check_count("idle", 0, pulses);
        check_count("idle", 0, ones_l + ones_r);
        finish_test("idle");
    endtask

    task automatic test_step();
        convert("step", 18'sd100000, -18'sd50001);
        finish_test("step");
    endtask

    task automatic test_extremes();
        convert("extremes", fs_pos, fs_pos);
        convert("extremes", fs_neg, fs_neg);
        convert("extremes", fs_pos, fs_neg);
        convert("extremes", fs_neg, fs_pos);
        finish_test("extremes");
    endtask

    task automatic test_random();
        lpf_pkg::sample_t xl;
        lpf_pkg::sample_t xr;
        repeat (20) begin
            xl = lcg_sample();
            xr = lcg_sample();
            convert("random", xl, xr);
            // About 60 cycles from strobe to strobe
            if (conv_cycles < 53) wait_cycles(53 - conv_cycles);
        end
        finish_test("random");
    endtask

    task automatic test_busy_drop();
        int pulses;
        predict(18'sd1234, -18'sd4321);
        send_input(18'sd1234, -18'sd4321);
        wait_cycles(3);
        send_input(18'sd77777, 18'sd77777);
        collect_outputs("busy_drop");
        pulses = 0;
        repeat (60) begin
            @(negedge clk);
            pulses += sample_out_rdy;
        end
        check_count("busy_drop", 0, pulses);
        // History must still hold the first input
        convert("busy_drop", -18'sd999, 18'sd3);
        finish_test("busy_drop");
    endtask

    task automatic test_density();
        int ones_l;
        int ones_r;
        convert("density", 18'sd0, 18'sd0);
        count_ones(256, ones_l, ones_r);
        check_density("density", 126, 130, ones_l);
        check_density("density", 126, 130, ones_r);
        convert("density", half_pos, half_pos);
        count_ones(256, ones_l, ones_r);
        check_density("density", 188, 196, ones_l);
        check_density("density", 188, 196, ones_r);
        finish_test("density");
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        lcg_state     = 32'hc43bf672;
        p1_l          = 0;
        p1_r          = 0;
        p2_l          = 0;
        p2_r          = 0;
        test_errors   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        conv_cycles   = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        test_idle();
        test_step();
        test_extremes();
        test_random();
        test_busy_drop();
        test_density();

        if (dut_i.assert_i.assert_fails != 0) begin
            $display("%0d assertion failures in lpf_chain", dut_i.assert_i.assert_fails);
            tests_failed++;
        end
        $display("passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/lpf_pkg.sv
verilog/sample_fifo.sv
verilog/interp_2x.sv
verilog/mac_unit.sv
verilog/sigma_delta_mod.sv
verilog/lpf_chain.sv
test/lpf_chain_assert.sv
test/lpf_chain_tb.sv

/* Bender.yml */
package:
  name: lpf_chain

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/lpf_pkg.sv
      - verilog/sample_fifo.sv
      - verilog/interp_2x.sv
      - verilog/mac_unit.sv
      - verilog/sigma_delta_mod.sv
      - verilog/lpf_chain.sv
  - target: test
    files:
      - test/lpf_chain_assert.sv
      - test/lpf_chain_tb.sv
